/* hw/rsa_pkg.sv */
package rsa_pkg;

    // operand geometry
    localparam int rsa_bits      = 256;
    localparam int rsa_bytes     = rsa_bits / 8;
    localparam int tx_bytes      = rsa_bytes - 1;  // top byte of plaintext is never sent
    localparam int bit_cnt_bits  = $clog2(rsa_bits + 1);
    localparam int exp_idx_bits  = $clog2(rsa_bits);
    localparam int byte_cnt_bits = $clog2(rsa_bytes);

    localparam logic [byte_cnt_bits-1:0] last_rx_byte = byte_cnt_bits'(rsa_bytes - 1);
    localparam logic [byte_cnt_bits-1:0] last_tx_byte = byte_cnt_bits'(tx_bytes - 1);

    // serial port register map
    localparam int avm_addr_bits = 5;
    localparam logic [avm_addr_bits-1:0] rx_base     = 5'd0;
    localparam logic [avm_addr_bits-1:0] tx_base     = 5'd4;
    localparam logic [avm_addr_bits-1:0] status_base = 5'd8;
    localparam int tx_ok_bit = 6;
    localparam int rx_ok_bit = 7;

    typedef logic [rsa_bits-1:0] rsa_word_t;

    localparam rsa_word_t word_one = rsa_word_t'(1);

    // core FSM encoding
    localparam logic [2:0] core_idle      = 3'd0;
    localparam logic [2:0] core_prep_base = 3'd1;
    localparam logic [2:0] core_prep_one  = 3'd2;
    localparam logic [2:0] core_mul       = 3'd3;
    localparam logic [2:0] core_sqr       = 3'd4;
    localparam logic [2:0] core_convert   = 3'd5;

    // wrapper FSM encoding
    localparam logic [2:0] st_get_n     = 3'd0;
    localparam logic [2:0] st_get_d     = 3'd1;
    localparam logic [2:0] st_get_data  = 3'd2;
    localparam logic [2:0] st_req_calc  = 3'd3;
    localparam logic [2:0] st_wait_calc = 3'd4;
    localparam logic [2:0] st_send_data = 3'd5;

    typedef struct packed {
        logic [23:0] pad_hi;
        logic        rx_ok;   // bit 7
        logic        tx_ok;   // bit 6
        logic [5:0]  pad_lo;
    } avm_status_s;

    typedef struct packed {
        logic [23:0] pad;
        logic [7:0]  value;
    } avm_data_s;

    // status read or data byte, depending on the address
    typedef union packed {
        avm_status_s status;
        avm_data_s   data;
    } avm_word_u;

endpackage

/* hw/rsa_mont_mult.sv */
`timescale 1ns/1ns

module rsa_mont_mult (
    input  logic              avm_clk,
    input  logic              avm_rst,
    input  logic              start,
    input  rsa_pkg::rsa_word_t a,
    input  rsa_pkg::rsa_word_t b,
    input  rsa_pkg::rsa_word_t n,
    output rsa_pkg::rsa_word_t result,
    output logic              done
);
    import rsa_pkg::*;

    logic [rsa_bits:0]    s_r;      // partial sum, stays below 2n
    logic [rsa_bits:0]    s_next;
    logic [rsa_bits:0]    s_sub;
    logic [rsa_bits+1:0]  sum_b;
    logic [rsa_bits+1:0]  sum_n;
    rsa_word_t            a_sh_r;   // remaining multiplier bits
    logic [bit_cnt_bits-1:0] cnt_r;
    logic                 busy_r;
    logic                 a_bit;

    // one radix-2 step; the start cycle already consumes a[0]
    always_comb begin
        a_bit  = start ? a[0] : a_sh_r[0];
        sum_b  = (start ? '0 : {1'b0, s_r}) + (a_bit ? {2'b00, b} : '0);
        sum_n  = sum_b + (sum_b[0] ? {2'b00, n} : '0);  // make it even
        s_next = sum_n[rsa_bits+1:1];
        s_sub  = s_r - {1'b0, n};
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy_r <= 1'b0;
            cnt_r  <= '0;
            done   <= 1'b0;
        end
        else begin
            done <= 1'b0;
            if (start) begin
                busy_r <= 1'b1;
                cnt_r  <= bit_cnt_bits'(1);
            end
            else if (busy_r) begin
                if (cnt_r == bit_cnt_bits'(rsa_bits)) begin  // final subtraction cycle
                    busy_r <= 1'b0;
                    done   <= 1'b1;
                end
                else begin
                    cnt_r <= cnt_r + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            s_r    <= s_next;
            a_sh_r <= a >> 1;
        end
        else if (busy_r && cnt_r != bit_cnt_bits'(rsa_bits)) begin
            s_r    <= s_next;
            a_sh_r <= a_sh_r >> 1;
        end
        else if (busy_r) begin
            result <= (s_r >= {1'b0, n}) ? s_sub[rsa_bits-1:0] : s_r[rsa_bits-1:0];
        end
    end

endmodule

/* hw/rsa_mod_prep.sv */
`timescale 1ns/1ns

module rsa_mod_prep (
    input  logic              avm_clk,
    input  logic              avm_rst,
    input  logic              start,
    input  rsa_pkg::rsa_word_t base,
    input  rsa_pkg::rsa_word_t n,
    output rsa_pkg::rsa_word_t result,
    output logic              done
);
    import rsa_pkg::*;

    rsa_word_t            r_r;
    logic [rsa_bits:0]    dbl;     // one bit of headroom for 2r
    logic [rsa_bits:0]    red;
    logic [bit_cnt_bits-1:0] cnt_r;
    logic                 busy_r;

    always_comb begin
        dbl = {r_r, 1'b0};
        red = (dbl >= {1'b0, n}) ? dbl - {1'b0, n} : dbl;
    end

    assign result = r_r;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy_r <= 1'b0;
            cnt_r  <= '0;
            done   <= 1'b0;
        end
        else begin
            done <= 1'b0;
            if (start) begin
                busy_r <= 1'b1;
                cnt_r  <= '0;
            end
            else if (busy_r) begin
                cnt_r <= cnt_r + 1'b1;
                if (cnt_r == bit_cnt_bits'(rsa_bits - 1)) begin  // 256th doubling
                    busy_r <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    // base must already be below n, r stays reduced after every step
    always_ff @(posedge avm_clk) begin
        if (start)
            r_r <= base;
        else if (busy_r)
            r_r <= red[rsa_bits-1:0];
    end

endmodule

/* hw/rsa_core.sv */
`timescale 1ns/1ns

module rsa_core (
    input  logic              avm_clk,
    input  logic              avm_rst,
    input  logic              start,
    input  rsa_pkg::rsa_word_t base,
    input  rsa_pkg::rsa_word_t exponent,
    input  rsa_pkg::rsa_word_t n,
    output rsa_pkg::rsa_word_t result,
    output logic              done
);
    import rsa_pkg::*;

    logic [2:0]              state_r;
    logic [exp_idx_bits-1:0] bit_idx_r;
    logic [exp_idx_bits-1:0] next_idx;
    rsa_word_t               pow_r;   // base^(2^i) in Montgomery form
    rsa_word_t               acc_r;   // running product in Montgomery form

    logic      prep_start_r;
    rsa_word_t prep_base;
    rsa_word_t prep_result;
    logic      prep_done;

    logic      mm_start_r;
    rsa_word_t mm_a;
    rsa_word_t mm_b;
    rsa_word_t mm_result;
    logic      mm_done;

    // second prep pass turns 1 into R mod n
    assign prep_base = (state_r == core_prep_one) ? word_one : base;
    assign next_idx  = bit_idx_r + 1'b1;

    // shared multiplier operand selector
    always_comb begin
        case (state_r)
            core_mul: begin
                mm_a = acc_r;
                mm_b = pow_r;
            end
            core_convert: begin
                mm_a = acc_r;
                mm_b = word_one;   // leaves the Montgomery domain
            end
            default: begin
                mm_a = pow_r;
                mm_b = pow_r;
            end
        endcase
    end

    rsa_mod_prep rsa_mod_prep_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (prep_start_r),
        .base    (prep_base),
        .n       (n),
        .result  (prep_result),
        .done    (prep_done)
    );

    rsa_mont_mult rsa_mont_mult_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mm_start_r),
        .a       (mm_a),
        .b       (mm_b),
        .n       (n),
        .result  (mm_result),
        .done    (mm_done)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r      <= core_idle;
            bit_idx_r    <= '0;
            prep_start_r <= 1'b0;
            mm_start_r   <= 1'b0;
            done         <= 1'b0;
        end
        else begin
            prep_start_r <= 1'b0;
            mm_start_r   <= 1'b0;
            done         <= 1'b0;
            case (state_r)
                core_idle: if (start) begin
                    state_r      <= core_prep_base;
                    prep_start_r <= 1'b1;
                end
                core_prep_base: if (prep_done) begin
                    state_r      <= core_prep_one;
                    prep_start_r <= 1'b1;
                end
                core_prep_one: if (prep_done) begin
                    bit_idx_r  <= '0;
                    state_r    <= exponent[0] ? core_mul : core_sqr;
                    mm_start_r <= 1'b1;
                end
                core_mul: if (mm_done) begin
                    state_r    <= core_sqr;
                    mm_start_r <= 1'b1;
                end
                core_sqr: if (mm_done) begin
                    mm_start_r <= 1'b1;
                    if (bit_idx_r == exp_idx_bits'(rsa_bits - 1)) begin
                        state_r <= core_convert;
                    end
                    else begin
                        bit_idx_r <= next_idx;
                        state_r   <= exponent[next_idx] ? core_mul : core_sqr;
                    end
                end
                core_convert: if (mm_done) begin
                    done    <= 1'b1;
                    state_r <= core_idle;
                end
                default: state_r <= core_idle;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        case (state_r)
            core_prep_base: if (prep_done) pow_r  <= prep_result;
            core_prep_one:  if (prep_done) acc_r  <= prep_result;
            core_mul:       if (mm_done)   acc_r  <= mm_result;
            core_sqr:       if (mm_done)   pow_r  <= mm_result;
            core_convert:   if (mm_done)   result <= mm_result;
            default: ;
        endcase
    end

endmodule

/* hw/rsa_wrapper.sv */
`timescale 1ns/1ns

module rsa_wrapper (
    input  logic                             avm_clk,
    input  logic                             avm_rst,
    output logic [rsa_pkg::avm_addr_bits-1:0] avm_address,
    output logic                             avm_read,
    input  rsa_pkg::avm_word_u               avm_readdata,
    output logic                             avm_write,
    output rsa_pkg::avm_word_u               avm_writedata,
    input  logic                             avm_waitrequest
);
    import rsa_pkg::*;

    logic [2:0]               state_r, state_w;
    logic [byte_cnt_bits-1:0] cnt_r, cnt_w;       // byte within current operand
    logic [avm_addr_bits-1:0] addr_r, addr_w;
    logic                     read_r, read_w;
    logic                     write_r, write_w;
    logic                     start_r, start_w;   // core start pulse

    rsa_word_t n_r, n_w;       // modulus, kept across messages
    rsa_word_t d_r, d_w;       // private exponent
    rsa_word_t enc_r, enc_w;   // ciphertext
    rsa_word_t dec_r, dec_w;   // plaintext, shifted out from the top

    rsa_word_t core_result;
    logic      core_done;
    logic      xfer_done;
    logic [7:0] rx_byte;

    assign avm_address = addr_r;
    assign avm_read    = read_r;
    assign avm_write   = write_r;

    always_comb begin
        avm_writedata.data.pad   = '0;
        avm_writedata.data.value = dec_r[rsa_bits-9 -: 8];  // bits 247..240
    end

    assign xfer_done = (read_r || write_r) && !avm_waitrequest;
    assign rx_byte   = avm_readdata.data.value;

    rsa_core rsa_core_i (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (start_r),
        .base     (enc_r),
        .exponent (d_r),
        .n        (n_r),
        .result   (core_result),
        .done     (core_done)
    );

    always_comb begin
        state_w = state_r;
        cnt_w   = cnt_r;
        addr_w  = addr_r;
        read_w  = read_r;
        write_w = write_r;
        start_w = 1'b0;
        n_w     = n_r;
        d_w     = d_r;
        enc_w   = enc_r;
        dec_w   = dec_r;

        case (state_r)
            st_get_n, st_get_d, st_get_data: begin
                read_w  = 1'b1;
                write_w = 1'b0;
                if (xfer_done) begin
                    if (addr_r == status_base) begin
                        if (avm_readdata.status.rx_ok)
                            addr_w = rx_base;   // byte waiting, fetch it
                    end
                    else begin
                        addr_w = status_base;
                        case (state_r)
                            st_get_n: n_w = {n_r[rsa_bits-9:0], rx_byte};
                            st_get_d: d_w = {d_r[rsa_bits-9:0], rx_byte};
                            default:  enc_w = {enc_r[rsa_bits-9:0], rx_byte};
                        endcase
                        if (cnt_r == last_rx_byte) begin
                            cnt_w = '0;
                            case (state_r)
                                st_get_n: state_w = st_get_d;
                                st_get_d: state_w = st_get_data;
                                default: begin
                                    state_w = st_req_calc;
                                    read_w  = 1'b0;   // bus idle during calculation
                                end
                            endcase
                        end
                        else begin
                            cnt_w = cnt_r + 1'b1;
                        end
                    end
                end
            end
            st_req_calc: begin
                start_w = 1'b1;
                state_w = st_wait_calc;
            end
            st_wait_calc: begin
                if (core_done) begin
                    dec_w   = core_result;
                    state_w = st_send_data;
                    addr_w  = status_base;
                    read_w  = 1'b1;
                end
            end
            st_send_data: begin
                if (xfer_done) begin
                    if (addr_r == status_base) begin
                        if (avm_readdata.status.tx_ok) begin
                            addr_w  = tx_base;
                            read_w  = 1'b0;
                            write_w = 1'b1;
                        end
                    end
                    else begin
                        // byte accepted by the port
                        addr_w  = status_base;
                        write_w = 1'b0;
                        read_w  = 1'b1;
                        dec_w   = dec_r << 8;
                        if (cnt_r == last_tx_byte) begin
                            cnt_w   = '0;
                            state_w = st_get_data;
                        end
                        else begin
                            cnt_w = cnt_r + 1'b1;
                        end
                    end
                end
            end
            default: state_w = st_get_n;
        endcase
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r <= st_get_n;
            cnt_r   <= '0;
            addr_r  <= status_base;
            read_r  <= 1'b0;
            write_r <= 1'b0;
            start_r <= 1'b0;
        end
        else begin
            state_r <= state_w;
            cnt_r   <= cnt_w;
            addr_r  <= addr_w;
            read_r  <= read_w;
            write_r <= write_w;
            start_r <= start_w;
        end
    end

    always_ff @(posedge avm_clk) begin
        n_r   <= n_w;
        d_r   <= d_w;
        enc_r <= enc_w;
        dec_r <= dec_w;
    end

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic avm_clk,
    output logic avm_rst
);

    initial begin
        avm_clk = 1'b0;
        avm_rst <= 1'b1;
        repeat (4) @(posedge avm_clk);
        avm_rst <= 1'b0;  // released on the 4th rising edge
    end

    always #5 avm_clk = ~avm_clk;  // 10 ns period

endmodule

/* tests/rsa_uart_model.sv */
`timescale 1ns/1ns

module rsa_uart_model #(
    parameter int unsigned seed = 0
) (
    input  logic                              avm_clk,
    input  logic                              avm_rst,
    input  logic [rsa_pkg::avm_addr_bits-1:0] avm_address,
    input  logic                              avm_read,
    output rsa_pkg::avm_word_u                avm_readdata,
    input  logic                              avm_write,
    input  rsa_pkg::avm_word_u                avm_writedata,
    output logic                              avm_waitrequest,
    output logic                              tx_valid,
    output rsa_pkg::avm_word_u                tx_word,
    output int unsigned                       rx_reads,
    output int unsigned                       tx_writes
);
    import rsa_pkg::*;

    logic [7:0]  rx_q [$];   // bytes waiting to be read by the master
    int unsigned wait_left;  // waitrequest cycles left for the current transfer
    int unsigned rx_hold;    // rx_ok kept low while nonzero
    int unsigned tx_hold;    // tx_ok kept low while nonzero
    avm_word_u   rd;

    task automatic push_rx(input logic [7:0] value);
        rx_q.push_back(value);
    endtask

    // all random draws come from this one seeded process
    initial begin
        void'($urandom(seed));
        avm_waitrequest <= 1'b1;
        avm_readdata    <= '0;
        tx_valid        <= 1'b0;
        tx_word         <= '0;
        rx_reads        <= 0;
        tx_writes       <= 0;
        wait_left = 0;
        rx_hold   = 0;
        tx_hold   = 0;
        forever begin
            @(posedge avm_clk);
            tx_valid <= 1'b0;
            if (rx_hold != 0) rx_hold = rx_hold - 1;
            if (tx_hold != 0) tx_hold = tx_hold - 1;
            if (avm_rst) begin
                avm_waitrequest <= 1'b1;
            end
            else if ((avm_read || avm_write) && !avm_waitrequest) begin
                // transfer completes in this cycle
                if (avm_write && avm_address == tx_base) begin
                    tx_valid  <= 1'b1;
                    tx_word   <= avm_writedata;
                    tx_writes <= tx_writes + 1;
                    tx_hold = $urandom % 6;
                end
                if (avm_read && avm_address == rx_base) begin
                    if (rx_q.size() != 0)
                        void'(rx_q.pop_front());
                    rx_reads <= rx_reads + 1;
                    rx_hold = $urandom % 6;
                end
                avm_waitrequest <= 1'b1;
                wait_left = $urandom % 4;
            end
            else if (avm_read || avm_write) begin
                if (wait_left != 0) begin
                    wait_left = wait_left - 1;
                end
                else begin
                    rd = '0;
                    if (avm_address == rx_base && rx_q.size() != 0)
                        rd.data.value = rx_q[0];
                    else if (avm_address == status_base) begin
                        // raw bit positions of the register map
                        rd[rx_ok_bit] = (rx_q.size() != 0) && (rx_hold == 0);
                        rd[tx_ok_bit] = (tx_hold == 0);
                    end
                    avm_readdata    <= rd;
                    avm_waitrequest <= 1'b0;  // done next cycle
                end
            end
        end
    end

endmodule

/* tests/rsa_properties.sv */
`timescale 1ns/1ns

module rsa_properties (
    input logic                              avm_clk,
    input logic                              avm_rst,
    input logic [rsa_pkg::avm_addr_bits-1:0] avm_address,
    input logic                              avm_read,
    input rsa_pkg::avm_word_u                avm_readdata,
    input logic                              avm_write,
    input rsa_pkg::avm_word_u                avm_writedata,
    input logic                              avm_waitrequest
);
    import rsa_pkg::*;

    logic        status_done;
    int unsigned fail_cnt = 0;  // failed assertion attempts

    assign status_done = avm_read && !avm_waitrequest && (avm_address == status_base);

    no_read_and_write: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(avm_read && avm_write))
        else begin
            fail_cnt++;
            $error("read and write are high together");
        end

    // writedata only carries meaning during a write
    held_while_waiting: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable(avm_address) && $stable(avm_read) && $stable(avm_write)
            && (!avm_write || $stable(avm_writedata)))
        else begin
            fail_cnt++;
            $error("transfer changed while waitrequest was high");
        end

    rx_after_status: assert property (@(posedge avm_clk) disable iff (avm_rst)
        avm_read && (avm_address == rx_base) && ($past(avm_address) != rx_base)
        |-> $past(status_done && avm_readdata.status.rx_ok))
        else begin
            fail_cnt++;
            $error("rx read without a status read showing rx_ok");
        end

    tx_after_status: assert property (@(posedge avm_clk) disable iff (avm_rst)
        avm_write && !$past(avm_write)
        |-> $past(status_done && avm_readdata.status.tx_ok))
        else begin
            fail_cnt++;
            $error("tx write without a status read showing tx_ok");
        end

endmodule

bind rsa_wrapper rsa_properties rsa_properties_i (
    .avm_clk         (avm_clk),
    .avm_rst         (avm_rst),
    .avm_address     (avm_address),
    .avm_read        (avm_read),
    .avm_readdata    (avm_readdata),
    .avm_write       (avm_write),
    .avm_writedata   (avm_writedata),
    .avm_waitrequest (avm_waitrequest)
);

/* tests/tb_rsa.sv */
`timescale 1ns/1ns

module tb_rsa;
    import rsa_pkg::*;

    typedef struct packed {
        rsa_word_t ct;
        rsa_word_t pt;   // filled by the reference model
    } vector_s;

    localparam int entries   = 6;
    localparam int wide_bits = 2 * rsa_bits;
    localparam int unsigned timeout_cycles =
        entries * (rsa_bits + 1) * (2 * rsa_bits + 2) + 5000 * entries;
    localparam rsa_word_t key_n =
        256'h00d4a71f_936b2ec8_0577f13a_9ce4620b_5d8f31c6_e9a27b4d_08f5e39c_61b7a53f;
    localparam rsa_word_t key_d =
        256'h3b9f2c71_e08d45a6_91fc37b2_6a4e0d18_c57b93e2_0f6d18a4_b2e95c07_7d31a6f9;

    logic                     avm_clk;
    logic                     avm_rst;
    logic [avm_addr_bits-1:0] avm_address;
    logic                     avm_read;
    logic                     avm_write;
    logic                     avm_waitrequest;
    avm_word_u                avm_readdata;
    avm_word_u                avm_writedata;
    logic                     tx_valid;
    avm_word_u                tx_word;
    int unsigned              rx_reads;
    int unsigned              tx_writes;

    vector_s     vectors [entries];
    avm_word_u   tx_seen [$];
    int unsigned cycle_cnt = 0;
    int          checks = 0;
    int          errors = 0;

    tb_clock_gen tb_clock_gen_i (.avm_clk(avm_clk), .avm_rst(avm_rst));

    rsa_uart_model #(.seed(32'hd916035c)) uart_i (
        .avm_clk(avm_clk), .avm_rst(avm_rst), .avm_address(avm_address),
        .avm_read(avm_read), .avm_readdata(avm_readdata), .avm_write(avm_write),
        .avm_writedata(avm_writedata), .avm_waitrequest(avm_waitrequest),
        .tx_valid(tx_valid), .tx_word(tx_word), .rx_reads(rx_reads), .tx_writes(tx_writes)
    );

    rsa_wrapper rsa_wrapper_i (
        .avm_clk(avm_clk), .avm_rst(avm_rst), .avm_address(avm_address),
        .avm_read(avm_read), .avm_readdata(avm_readdata), .avm_write(avm_write),
        .avm_writedata(avm_writedata), .avm_waitrequest(avm_waitrequest)
    );

    // plain square-and-multiply, products kept at double width
    function automatic rsa_word_t mod_exp(input rsa_word_t base, input rsa_word_t e,
                                          input rsa_word_t m);
        logic [wide_bits-1:0] acc;
        logic [wide_bits-1:0] pw;
        logic [wide_bits-1:0] wide_m;
        wide_m = wide_bits'(m);
        acc    = wide_bits'(1);
        pw     = wide_bits'(base) % wide_m;
        for (int i = 0; i < rsa_bits; i++) begin
            if (e[i]) acc = (acc * pw) % wide_m;
            pw = (pw * pw) % wide_m;
        end
        return acc[rsa_bits-1:0];
    endfunction

    task automatic check_word(input string name, input rsa_word_t got, input rsa_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input avm_word_u got, input avm_word_u exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [avm_addr_bits-1:0] got,
                              input logic [avm_addr_bits-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int unsigned got,
                               input int unsigned exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // operand goes out most significant byte first
    task automatic push_word(input rsa_word_t w);
        for (int b = rsa_bytes - 1; b >= 0; b--)
            uart_i.push_rx(w[8*b +: 8]);
    endtask

    always @(posedge avm_clk) begin
        if (tx_valid)
            tx_seen.push_back(tx_word);
    end

    always @(posedge avm_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: the DUT did not finish within %0d cycles", timeout_cycles);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        rsa_word_t got_pt;
        avm_word_u got_w;
        avm_word_u exp_w;
        int        errors_before;

        vectors[0].ct = '0;
        vectors[1].ct = word_one;
        vectors[2].ct = rsa_word_t'(2);
        vectors[3].ct = 256'h0012ab34_cd56ef78_9a0b1c2d_3e4f5061_72839405_a6b7c8d9_eaf10213_24354657;
        vectors[4].ct = 256'h00a0b1c2_d3e4f506_17283940_5a6b7c8d_9eaf1b2c_3d4e5f60_71829304_a5b6c7d8;
        vectors[5].ct = key_n - 1;
        for (int k = 0; k < entries; k++)
            vectors[k].pt = mod_exp(vectors[k].ct, key_d, key_n);

        // bus stays idle through reset and the cycle after
        do begin
            @(negedge avm_clk);
            check_bit("avm_read", avm_read, 1'b0);
            check_bit("avm_write", avm_write, 1'b0);
        end while (avm_rst);
        while (!(avm_read || avm_write))
            @(negedge avm_clk);
        check_bit("avm_read", avm_read, 1'b1);
        check_addr("avm_address", avm_address, status_base);
        $display("test reset: %s", (errors == 0) ? "ok" : "MISMATCH");

        push_word(key_n);
        push_word(key_d);
        for (int k = 0; k < entries; k++) begin
            errors_before = errors;
            push_word(vectors[k].ct);
            while (tx_seen.size() < tx_bytes)
                @(negedge avm_clk);
            got_pt = '0;
            for (int i = 0; i < tx_bytes; i++) begin
                got_w = tx_seen.pop_front();
                exp_w = '0;
                exp_w.data.value = vectors[k].pt[rsa_bits-9-8*i -: 8];
                check_byte($sformatf("avm_writedata byte %0d", i), got_w, exp_w);
                got_pt = {got_pt[rsa_bits-9:0], got_w.data.value};
            end
            check_word("plaintext", got_pt, vectors[k].pt);
            check_count("rx reads", rx_reads, rsa_bytes * (k + 3));
            check_count("tx writes", tx_writes, tx_bytes * (k + 1));
            $display("test %0d ct=%h: %s", k, vectors[k].ct,
                     (errors == errors_before) ? "ok" : "MISMATCH");
        end

        // bus protocol checker attached to the DUT
        check_count("assertion failures", rsa_wrapper_i.rsa_properties_i.fail_cnt, 0);

        $display("checks %0d, errors %0d, tests %0d", checks, errors, entries + 1);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* list.f */
hw/rsa_pkg.sv
hw/rsa_mont_mult.sv
hw/rsa_mod_prep.sv
hw/rsa_core.sv
hw/rsa_wrapper.sv
tests/tb_clock_gen.sv
tests/rsa_uart_model.sv
tests/rsa_properties.sv
tests/tb_rsa.sv

/* Bender.yml */
package:
  name: rsa_decrypt

sources:
  - files:
      - hw/rsa_pkg.sv
      - hw/rsa_mont_mult.sv
      - hw/rsa_mod_prep.sv
      - hw/rsa_core.sv
      - hw/rsa_wrapper.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/rsa_uart_model.sv
      - tests/rsa_properties.sv
      - tests/tb_rsa.sv
